/* design/es_cfg.svh */
// Build-time configuration of the entropy source
// FIFO depth must be a power of two so the pointers wrap on their own
// Symbols per word times four must equal the 32-bit word width
// Register addresses are byte offsets on the four-bit register bus
`ifndef ES_CFG_SVH
`define ES_CFG_SVH

////////////////////
// Sizing
////////////////////

// Words held between the sampler and the consumers
`define ES_FIFO_DEPTH 4
`define ES_SYMS_PER_WORD 8
// Repetition threshold out of reset
`define ES_REPCNT_DEFAULT 4'd6

////////////////////
// Register map
////////////////////

`define ES_ADDR_CTRL   4'h0
`define ES_ADDR_THRESH 4'h4
`define ES_ADDR_STATUS 4'h8
`define ES_ADDR_DATA   4'hC
`endif

/* design/es_types_pkg.sv */
// Data-path types of the entropy source
// Level width covers a FIFO of up to seven words
// Threshold and repeat count share one four-bit type

package es_types_pkg;

  ////////////////////
  // Data path
  ////////////////////

  // One noise symbol from the RNG
  typedef logic [3:0] es_symbol_t;

  // Packed entropy word, first symbol in bits 3:0
  typedef logic [31:0] es_word_t;

  // FIFO fill level, zero up to full
  typedef logic [2:0] es_level_t;

  // Run length of equal symbols, also used for the threshold
  typedef logic [3:0] rep_cnt_t;

  // Health failures, saturates at all ones
  typedef logic [7:0] fail_cnt_t;

  ////////////////////
  // Handshake FSM
  ////////////////////

  // IDLE waits for req, ACK builds the response, WAIT_DROP holds ack until req falls
  typedef enum logic [1:0] {
    IDLE,
    ACK,
    WAIT_DROP
  } hs_state_e;

endpackage

/* design/es_bus_pkg.sv */
// Bus bundles of the entropy source
// Register bus and hardware entropy interface both use a four-phase req/ack
// Fields stay stable from req high until ack falls

package es_bus_pkg;

  // Register byte address
  typedef logic [3:0] reg_addr_t;

  ////////////////////
  // Register bus
  ////////////////////

  typedef struct packed {
    logic                   req;
    logic                   we;
    reg_addr_t              addr;
    es_types_pkg::es_word_t wdata;
  } reg_req_t;

  typedef struct packed {
    logic                   ack;
    es_types_pkg::es_word_t rdata;
  } reg_rsp_t;

  ////////////////////
  // Entropy interface
  ////////////////////

  typedef struct packed {
    logic req;
  } es_hw_req_t;

  typedef struct packed {
    logic                   ack;
    es_types_pkg::es_word_t bits;
  } es_hw_rsp_t;

  // One consumer's view of the shared FIFO
  typedef struct packed {
    logic                   pop_req;
    logic                   grant;
    es_types_pkg::es_word_t data;
  } fifo_port_t;

endpackage

/* design/es_health_sampler.sv */
// Repetition-count health test and word packing
// Symbols are taken only while enable_i is high; the source is never stalled
// A failing symbol is dropped along with the partial word
// word_o is valid while push_o is high
`timescale 1ns/10ps
`include "es_cfg.svh"

module es_health_sampler (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     enable_i,
  input  es_types_pkg::rep_cnt_t   thresh_i,
  input  es_types_pkg::es_symbol_t rng_sym_i,
  input  logic                     rng_valid_i,
  output logic                     push_o,
  output es_types_pkg::es_word_t   word_o,
  output logic                     fail_o
);
  import es_types_pkg::*;

  localparam int SymCntW = $clog2(`ES_SYMS_PER_WORD);
  localparam int SymW    = $bits(es_symbol_t);
  localparam int WordW   = $bits(es_word_t);

  es_symbol_t         prev_sym;
  rep_cnt_t           rep_cnt;
  rep_cnt_t           rep_cnt_nxt;
  logic [SymCntW-1:0] sym_cnt;
  logic               last_sym;
  es_word_t           pack_word;
  logic               sym_take;
  logic               rep_fail;
  logic               push_q;
  logic               fail_q;

  assign sym_take = enable_i & rng_valid_i;
  assign last_sym = (sym_cnt == SymCntW'(`ES_SYMS_PER_WORD - 1));

  // Run length including this symbol, zero count means no history yet
  assign rep_cnt_nxt = (rep_cnt != '0 && rng_sym_i == prev_sym) ? rep_cnt + 1'b1
                                                                 : rep_cnt_t'(1);
  assign rep_fail    = sym_take & (rep_cnt_nxt >= thresh_i);

  ////////////////////
  // Repetition count
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rep_cnt <= '0;
    end else if (!enable_i) begin
      rep_cnt <= '0;
    end else if (sym_take) begin
      // A failure starts a fresh run at the failing symbol
      rep_cnt <= rep_fail ? rep_cnt_t'(1) : rep_cnt_nxt;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sym_take) begin
      prev_sym <= rng_sym_i;
    end
  end

  ////////////////////
  // Word packing
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sym_cnt <= '0;
      push_q  <= 1'b0;
      fail_q  <= 1'b0;
    end else if (!enable_i) begin
      sym_cnt <= '0;
      push_q  <= 1'b0;
      fail_q  <= 1'b0;
    end else begin
      push_q <= 1'b0;
      fail_q <= rep_fail;
      if (rep_fail) begin
        sym_cnt <= '0;
      end else if (sym_take) begin
        push_q  <= last_sym;
        sym_cnt <= last_sym ? '0 : sym_cnt + 1'b1;
      end
    end
  end

  // New symbols enter at the top, so stale bits drop out after a full word
  always_ff @(posedge clk_i) begin
    if (sym_take && !rep_fail) begin
      pack_word <= {rng_sym_i, pack_word[WordW-1:SymW]};
    end
  end

  assign push_o = push_q;
  assign word_o = pack_word;
  assign fail_o = fail_q;

endmodule

/* design/es_fifo.sv */
// Entropy word FIFO
// A push while full is dropped, a pop while empty is ignored
// data_o shows the head word whenever empty_o is low
`timescale 1ns/10ps
`include "es_cfg.svh"

module es_fifo (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    flush_i,
  input  logic                    push_i,
  input  es_types_pkg::es_word_t  word_i,
  input  logic                    pop_i,
  output es_types_pkg::es_word_t  data_o,
  output logic                    empty_o,
  output es_types_pkg::es_level_t level_o
);
  import es_types_pkg::*;

  localparam int PtrW = $clog2(`ES_FIFO_DEPTH);

  es_word_t        mem [`ES_FIFO_DEPTH];
  logic [PtrW-1:0] wr_ptr;
  logic [PtrW-1:0] rd_ptr;
  es_level_t       count;
  logic            full;
  logic            wr_en;
  logic            rd_en;

  assign full    = (count == es_level_t'(`ES_FIFO_DEPTH));
  assign empty_o = (count == '0);
  assign wr_en   = push_i & ~full;
  assign rd_en   = pop_i & ~empty_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem[wr_ptr] <= word_i;
    end
  end

  assign data_o  = mem[rd_ptr];
  assign level_o = count;

endmodule

/* design/es_fifo_arbiter.sv */
// Round-robin arbiter for the two FIFO consumers
// At most one grant per cycle and none while the FIFO is empty
// The granted consumer must take the head word in the grant cycle
`timescale 1ns/10ps

module es_fifo_arbiter (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   empty_i,
  input  es_bus_pkg::fifo_port_t hw_port_i,
  input  es_bus_pkg::fifo_port_t fw_port_i,
  output logic                   hw_grant_o,
  output logic                   fw_grant_o,
  output logic                   pop_o
);

  logic last_hw;
  logic hw_req;
  logic fw_req;

  assign hw_req = hw_port_i.pop_req & ~empty_i;
  assign fw_req = fw_port_i.pop_req & ~empty_i;

  always_comb begin
    if (hw_req && fw_req) begin
      // Tie goes to whoever was not served last
      hw_grant_o = ~last_hw;
      fw_grant_o = last_hw;
    end else begin
      hw_grant_o = hw_req;
      fw_grant_o = fw_req;
    end
  end

  assign pop_o = hw_grant_o | fw_grant_o;

  ////////////////////
  // Last grant
  ////////////////////

  // Out of reset hw counts as last, so fw wins the first tie
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      last_hw <= 1'b1;
    end else if (pop_o) begin
      last_hw <= hw_grant_o;
    end
  end

endmodule

/* design/es_hw_if.sv */
// Hardware entropy interface toward the DRBG
// One word per four-phase transfer; ack waits for a FIFO grant
// bits is valid while ack is high, ack falls one cycle after req
`timescale 1ns/10ps

module es_hw_if (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  es_bus_pkg::es_hw_req_t es_hw_req_i,
  output es_bus_pkg::es_hw_rsp_t es_hw_rsp_o,
  output logic                   pop_req_o,
  input  logic                   grant_i,
  input  es_types_pkg::es_word_t fifo_data_i
);
  import es_types_pkg::*;

  hs_state_e state_q;
  hs_state_e state_d;
  es_word_t  bits_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:      if (es_hw_req_i.req) state_d = ACK;
      ACK:       if (grant_i) state_d = WAIT_DROP;
      WAIT_DROP: if (!es_hw_req_i.req) state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Head word is taken in the grant cycle
  always_ff @(posedge clk_i) begin
    if (grant_i) begin
      bits_q <= fifo_data_i;
    end
  end

  assign pop_req_o   = (state_q == ACK);
  assign es_hw_rsp_o = '{ack: (state_q == WAIT_DROP), bits: bits_q};

endmodule

/* design/es_reg_if.sv */
// Firmware register interface on a four-phase req/ack bus
// ack rises two cycles after req, later if a DATA read waits for a grant
// DATA read of an empty FIFO returns zero; writes to STATUS and DATA are dropped
// Unmapped addresses read as zero
`timescale 1ns/10ps
`include "es_cfg.svh"

module es_reg_if (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  es_bus_pkg::reg_req_t    reg_req_i,
  output es_bus_pkg::reg_rsp_t    reg_rsp_o,
  input  logic                    fail_i,
  input  es_types_pkg::es_level_t level_i,
  input  logic                    empty_i,
  input  es_types_pkg::es_word_t  fifo_data_i,
  output logic                    pop_req_o,
  input  logic                    grant_i,
  output logic                    enable_o,
  output es_types_pkg::rep_cnt_t  thresh_o
);
  import es_types_pkg::*;
  import es_bus_pkg::*;

  hs_state_e state_q;
  hs_state_e state_d;
  reg_req_t  req_q;
  es_word_t  rdata_q;
  es_word_t  rdata_d;
  fail_cnt_t fail_cnt;
  logic      enable_q;
  rep_cnt_t  thresh_q;
  logic      data_rd;
  logic      resolve;

  ////////////////////
  // Access FSM
  ////////////////////

  assign data_rd   = ~req_q.we & (req_q.addr == `ES_ADDR_DATA);
  assign pop_req_o = (state_q == ACK) & data_rd & ~empty_i;
  // Done unless a queued word still waits for its grant
  assign resolve   = (state_q == ACK) & ~(pop_req_o & ~grant_i);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:      if (reg_req_i.req) state_d = ACK;
      ACK:       if (resolve) state_d = WAIT_DROP;
      WAIT_DROP: if (!reg_req_i.req) state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Decode cycle captures the access
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && reg_req_i.req) begin
      req_q <= reg_req_i;
    end
  end

  ////////////////////
  // Read data
  ////////////////////

  always_comb begin
    rdata_d = '0;
    if (!req_q.we) begin
      case (req_q.addr)
        `ES_ADDR_CTRL:   rdata_d = es_word_t'(enable_q);
        `ES_ADDR_THRESH: rdata_d = es_word_t'(thresh_q);
        `ES_ADDR_STATUS: rdata_d = {16'h0, fail_cnt, 5'h0, level_i};
        `ES_ADDR_DATA:   rdata_d = grant_i ? fifo_data_i : '0;
        default:         rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (resolve) begin
      rdata_q <= rdata_d;
    end
  end

  ////////////////////
  // Control registers
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      enable_q <= 1'b0;
      thresh_q <= `ES_REPCNT_DEFAULT;
    end else if (resolve && req_q.we) begin
      case (req_q.addr)
        `ES_ADDR_CTRL:   enable_q <= req_q.wdata[0];
        `ES_ADDR_THRESH: thresh_q <= req_q.wdata[$bits(rep_cnt_t)-1:0];
        default:         enable_q <= enable_q;
      endcase
    end
  end

  // Saturating health-failure count
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      fail_cnt <= '0;
    end else if (fail_i && fail_cnt != '1) begin
      fail_cnt <= fail_cnt + 1'b1;
    end
  end

  assign enable_o  = enable_q;
  assign thresh_o  = thresh_q;
  assign reg_rsp_o = '{ack: (state_q == WAIT_DROP), rdata: rdata_q};

endmodule

/* design/entropy_src.sv */
// Entropy source top level
// Firmware and the DRBG share one entropy FIFO through a round-robin arbiter
// Clearing CTRL.enable flushes the FIFO and any partial word
// recov_alert_o is a one-cycle pulse per health failure
`timescale 1ns/10ps

module entropy_src (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  es_types_pkg::es_symbol_t rng_sym_i,
  input  logic                     rng_valid_i,
  output logic                     rng_enable_o,
  input  es_bus_pkg::reg_req_t     reg_req_i,
  output es_bus_pkg::reg_rsp_t     reg_rsp_o,
  input  es_bus_pkg::es_hw_req_t   es_hw_req_i,
  output es_bus_pkg::es_hw_rsp_t   es_hw_rsp_o,
  output logic                     intr_entropy_valid_o,
  output logic                     recov_alert_o
);
  import es_types_pkg::*;
  import es_bus_pkg::*;

  rep_cnt_t   thresh;
  logic       push;
  es_word_t   word;
  logic       fifo_flush;
  es_word_t   fifo_data;
  logic       fifo_empty;
  es_level_t  fifo_level;
  logic       fifo_pop;
  logic       hw_pop_req;
  logic       fw_pop_req;
  logic       hw_grant;
  logic       fw_grant;
  fifo_port_t hw_port;
  fifo_port_t fw_port;

  // Each consumer sees its own grant next to the shared head word
  assign hw_port = '{pop_req: hw_pop_req, grant: hw_grant, data: fifo_data};
  assign fw_port = '{pop_req: fw_pop_req, grant: fw_grant, data: fifo_data};

  assign fifo_flush           = ~rng_enable_o;
  assign intr_entropy_valid_o = ~fifo_empty;

  es_health_sampler u_sampler (
    .clk_i, .rst_n_i,
    .enable_i(rng_enable_o), .thresh_i(thresh),
    .rng_sym_i, .rng_valid_i,
    .push_o(push), .word_o(word), .fail_o(recov_alert_o)
  );

  es_fifo u_fifo (
    .clk_i, .rst_n_i,
    .flush_i(fifo_flush), .push_i(push), .word_i(word), .pop_i(fifo_pop),
    .data_o(fifo_data), .empty_o(fifo_empty), .level_o(fifo_level)
  );

  es_fifo_arbiter u_arb (
    .clk_i, .rst_n_i,
    .empty_i(fifo_empty), .hw_port_i(hw_port), .fw_port_i(fw_port),
    .hw_grant_o(hw_grant), .fw_grant_o(fw_grant), .pop_o(fifo_pop)
  );

  es_hw_if u_hw_if (
    .clk_i, .rst_n_i,
    .es_hw_req_i, .es_hw_rsp_o,
    .pop_req_o(hw_pop_req), .grant_i(hw_port.grant), .fifo_data_i(hw_port.data)
  );

  es_reg_if u_reg_if (
    .clk_i, .rst_n_i,
    .reg_req_i, .reg_rsp_o,
    .fail_i(recov_alert_o), .level_i(fifo_level), .empty_i(fifo_empty),
    .fifo_data_i(fw_port.data), .pop_req_o(fw_pop_req), .grant_i(fw_port.grant),
    .enable_o(rng_enable_o), .thresh_o(thresh)
  );

endmodule

/* verification/entropy_src_tb.sv */
// Testbench for the entropy source top level
// Symbols come from a fixed-seed LFSR and never repeat unless a row asks for a run
// Every row pushes one word, and a full FIFO drops it as the model does
`timescale 1ns/10ps
`include "es_cfg.svh"

module entropy_src_tb;
  import es_types_pkg::*;
  import es_bus_pkg::*;

  localparam int wait_limit = 40;

  typedef enum logic [1:0] {RD_NONE, RD_HW, RD_FW, RD_BOTH} reader_e;

  // Burst of pre symbols, a run of one symbol, then the rest of the word
  typedef struct packed {
    logic [3:0] pre;
    logic [3:0] run;
    rep_cnt_t   thresh;
    logic       fail;
    reader_e    reader;
  } row_t;

  logic       clk;
  logic       rst_n;
  es_symbol_t rng_sym;
  logic       rng_valid;
  logic       rng_enable;
  reg_req_t   reg_req;
  reg_rsp_t   reg_rsp;
  es_hw_req_t hw_req;
  es_hw_rsp_t hw_rsp;
  logic       intr_valid;
  logic       recov_alert;

  row_t       stim_table [12];
  es_word_t   model_q [$];
  es_symbol_t burst_q [$];
  logic [31:0] lfsr;
  es_symbol_t last_sym;
  logic       last_pop_hw;
  fail_cnt_t  fail_total;
  fail_cnt_t  alert_seen;
  int         errors;
  int         timeouts;
  es_word_t   rd;

  entropy_src entropy_src_inst (
    .clk_i(clk),
    .rst_n_i(rst_n),
    .rng_sym_i(rng_sym),
    .rng_valid_i(rng_valid),
    .rng_enable_o(rng_enable),
    .reg_req_i(reg_req),
    .reg_rsp_o(reg_rsp),
    .es_hw_req_i(hw_req),
    .es_hw_rsp_o(hw_rsp),
    .intr_entropy_valid_o(intr_valid),
    .recov_alert_o(recov_alert)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_word(input string name, input es_word_t got, input es_word_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input fail_cnt_t got, input fail_cnt_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_level(input string name, input es_level_t got, input es_level_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("At %0t no %s within %0d cycles", $time, what, wait_limit);
  endtask

  ////////////////////
  // Bus tasks
  ////////////////////

  // Outputs are sampled and inputs driven 5 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #5;
  endtask

  task automatic reg_access(input logic we, input reg_addr_t addr, input es_word_t wdata,
                            output es_word_t rdata);
    int n;
    n = 0;
    reg_req.we    = we;
    reg_req.addr  = addr;
    reg_req.wdata = wdata;
    reg_req.req   = 1'b1;
    while (!reg_rsp.ack && n < wait_limit) begin
      step();
      n++;
    end
    if (!reg_rsp.ack) report_timeout("register bus ack");
    rdata = reg_rsp.rdata;
    reg_req.req = 1'b0;
    n = 0;
    while (reg_rsp.ack && n < wait_limit) begin
      step();
      n++;
    end
    if (reg_rsp.ack) report_timeout("register bus ack release");
  endtask

  task automatic reg_write(input reg_addr_t addr, input es_word_t data);
    es_word_t ignored_rdata;
    reg_access(1'b1, addr, data, ignored_rdata);
  endtask

  task automatic reg_read(input reg_addr_t addr, output es_word_t data);
    reg_access(1'b0, addr, '0, data);
  endtask

  task automatic hw_read(output es_word_t word);
    int n;
    n = 0;
    hw_req.req = 1'b1;
    while (!hw_rsp.ack && n < wait_limit) begin
      step();
      n++;
    end
    if (!hw_rsp.ack) report_timeout("entropy interface ack");
    word = hw_rsp.bits;
    hw_req.req = 1'b0;
    n = 0;
    while (hw_rsp.ack && n < wait_limit) begin
      step();
      n++;
    end
    if (hw_rsp.ack) report_timeout("entropy interface ack release");
  endtask

  ////////////////////
  // Symbol source
  ////////////////////

  // Galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per symbol bit, redrawn until it differs from the last symbol
  function automatic es_symbol_t fresh_sym();
    es_symbol_t s;
    int b;
    s = last_sym;
    while (s == last_sym) begin
      for (b = 0; b < 4; b++) begin
        lfsr = lfsr_next(lfsr);
        s[b] = lfsr[0];
      end
    end
    last_sym = s;
    return s;
  endfunction

  function automatic row_t make_row(input logic [3:0] pre, input logic [3:0] run,
                                    input rep_cnt_t thresh, input logic fail,
                                    input reader_e reader);
    row_t r;
    r.pre    = pre;
    r.run    = run;
    r.thresh = thresh;
    r.fail   = fail;
    r.reader = reader;
    return r;
  endfunction

  task automatic build_burst(input row_t r, output es_word_t exp);
    es_symbol_t run_sym;
    int first;
    int post;
    int i;
    burst_q = {};
    repeat (r.pre) burst_q.push_back(fresh_sym());
    if (r.run != 0) begin
      run_sym = fresh_sym();
      repeat (r.run) burst_q.push_back(run_sym);
    end
    // After a failure the word is built only from the symbols that follow
    first = r.fail ? burst_q.size() : 0;
    post  = r.fail ? `ES_SYMS_PER_WORD : `ES_SYMS_PER_WORD - r.pre - r.run;
    repeat (post) burst_q.push_back(fresh_sym());
    exp = '0;
    for (i = 0; i < `ES_SYMS_PER_WORD; i++) begin
      exp[4*i +: 4] = burst_q[first + i];
    end
  endtask

  task automatic send_burst();
    foreach (burst_q[i]) begin
      rng_sym   = burst_q[i];
      rng_valid = 1'b1;
      step();
      if (recov_alert) alert_seen++;
    end
    rng_valid = 1'b0;
    // Push one cycle after the last symbol, level one cycle after the push
    repeat (2) begin
      step();
      if (recov_alert) alert_seen++;
    end
  endtask

  ////////////////////
  // Readers
  ////////////////////

  task automatic drain_fw();
    es_word_t got;
    while (model_q.size() != 0) begin
      reg_read(`ES_ADDR_DATA, got);
      check_word("DATA", got, model_q.pop_front());
      last_pop_hw = 1'b0;
    end
    // Empty FIFO reads as zero and pops nothing
    reg_read(`ES_ADDR_DATA, got);
    check_word("DATA while empty", got, '0);
  endtask

  task automatic read_both();
    es_word_t hw_word;
    es_word_t fw_word;
    es_word_t older;
    es_word_t newer;
    older = model_q.pop_front();
    newer = model_q.pop_front();
    fork
      hw_read(hw_word);
      reg_read(`ES_ADDR_DATA, fw_word);
    join
    // Tie goes to the consumer not served by the last pop
    if (last_pop_hw) begin
      check_word("DATA on tie", fw_word, older);
      check_word("es_hw_rsp_o.bits on tie", hw_word, newer);
    end else begin
      check_word("es_hw_rsp_o.bits on tie", hw_word, older);
      check_word("DATA on tie", fw_word, newer);
    end
    // Loser pops second, so the last grant stays where it was
  endtask

  task automatic apply_row(input row_t r);
    es_word_t exp;
    es_word_t got;
    es_word_t status;
    reg_write(`ES_ADDR_THRESH, es_word_t'(r.thresh));
    build_burst(r, exp);
    alert_seen = '0;
    send_burst();
    check_count("recov_alert_o pulses", alert_seen, fail_cnt_t'(r.fail));
    fail_total += fail_cnt_t'(r.fail);
    if (model_q.size() < `ES_FIFO_DEPTH) model_q.push_back(exp);
    reg_read(`ES_ADDR_STATUS, status);
    check_count("STATUS.fail_cnt", status[15:8], fail_total);
    check_level("STATUS.level", status[2:0], es_level_t'(model_q.size()));
    check_flag("intr_entropy_valid_o", intr_valid, model_q.size() != 0);
    case (r.reader)
      RD_HW: begin
        hw_read(got);
        check_word("es_hw_rsp_o.bits", got, model_q.pop_front());
        last_pop_hw = 1'b1;
      end
      RD_FW:   drain_fw();
      RD_BOTH: read_both();
      default: ;
    endcase
    check_flag("intr_entropy_valid_o", intr_valid, model_q.size() != 0);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    rst_n       = 1'b0;
    rng_sym     = '0;
    rng_valid   = 1'b0;
    reg_req     = '0;
    hw_req      = '0;
    lfsr        = 32'h5113;
    last_sym    = '0;
    last_pop_hw = 1'b1;
    fail_total  = '0;
    alert_seen  = '0;
    errors      = 0;
    timeouts    = 0;

    stim_table[0]  = make_row(0, 0, 4'd6, 1'b0, RD_NONE);
    // First pop after reset is a tie, so the arbiter reset state decides it
    stim_table[1]  = make_row(0, 0, 4'd6, 1'b0, RD_BOTH);
    stim_table[2]  = make_row(0, 0, 4'd6, 1'b0, RD_HW);
    stim_table[3]  = make_row(2, 3, 4'd3, 1'b1, RD_HW);
    stim_table[4]  = make_row(0, 0, 4'd6, 1'b0, RD_NONE);
    stim_table[5]  = make_row(2, 2, 4'd6, 1'b0, RD_FW);
    stim_table[6]  = make_row(0, 0, 4'd6, 1'b0, RD_NONE);
    stim_table[7]  = make_row(0, 0, 4'd6, 1'b0, RD_NONE);
    stim_table[8]  = make_row(0, 0, 4'd6, 1'b0, RD_NONE);
    stim_table[9]  = make_row(0, 0, 4'd6, 1'b0, RD_NONE);
    // Fifth queued word meets a full FIFO
    stim_table[10] = make_row(0, 0, 4'd6, 1'b0, RD_FW);
    stim_table[11] = make_row(1, 3, 4'd3, 1'b1, RD_NONE);

    repeat (2) step();
    rst_n = 1'b1;
    step();

    check_flag("rng_enable_o", rng_enable, 1'b0);
    check_flag("reg_rsp_o.ack", reg_rsp.ack, 1'b0);
    check_flag("es_hw_rsp_o.ack", hw_rsp.ack, 1'b0);
    check_flag("intr_entropy_valid_o", intr_valid, 1'b0);
    check_flag("recov_alert_o", recov_alert, 1'b0);
    reg_read(`ES_ADDR_THRESH, rd);
    check_word("THRESH", rd, es_word_t'(`ES_REPCNT_DEFAULT));
    reg_write(`ES_ADDR_CTRL, 32'h1);
    check_flag("rng_enable_o", rng_enable, 1'b1);
    reg_read(`ES_ADDR_CTRL, rd);
    check_word("CTRL", rd, 32'h1);

    foreach (stim_table[i]) begin
      apply_row(stim_table[i]);
    end

    // Disable flushes whatever is still queued
    reg_write(`ES_ADDR_CTRL, 32'h0);
    model_q.delete();
    check_flag("rng_enable_o", rng_enable, 1'b0);
    check_flag("intr_entropy_valid_o", intr_valid, 1'b0);
    reg_read(`ES_ADDR_STATUS, rd);
    check_level("STATUS.level", rd[2:0], '0);

    $display("Run complete with %0d mismatches and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+design
design/es_types_pkg.sv
design/es_bus_pkg.sv
design/es_health_sampler.sv
design/es_fifo.sv
design/es_fifo_arbiter.sv
design/es_hw_if.sv
design/es_reg_if.sv
design/entropy_src.sv
verification/entropy_src_tb.sv
